/* src.f */
hdl/cachePkg.sv
hdl/tagArray.sv
hdl/dataArray.sv
hdl/lruTracker.sv
hdl/cacheController.sv
hdl/cacheTop.sv
verification/tbClock.sv
verification/memModel.sv
verification/cacheTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the cache testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module cacheTb -f src.f -o cacheSim; then
	echo "verilator build failed"
	exit 1
fi

if ! output=$(./obj_dir/cacheSim); then
	echo "$output"
	echo "simulation exited with an error"
	exit 1
fi

echo "$output"
if echo "$output" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1

/* verification/cacheTb.sv */
`timescale 1ns/100ps

module cacheTb;

	localparam logic [31:0] ccrAddr = 32'hFFFF_FE92;
	localparam logic [31:0] fillKey = 32'h5A3C_96E1;
	localparam logic [31:0] lineX = 32'h0000_1230;
	localparam logic [31:0] missAddr = 32'h0000_5670;
	localparam logic [31:0] uncachedAddr = 32'h2000_0040;
	localparam logic [31:0] ioAddr = 32'hFFFF_0100;
	localparam logic [31:0] lruBase = 32'h0000_02A0;
	localparam int opCount = 40;
	localparam int opBound = 100;
	localparam int watchdogNs = (opCount * opBound + 20) * 10;

	logic        CLK;
	logic        RST_N;
	logic        reqValid;
	logic        reqWrite;
	logic [31:0] reqAddr;
	logic [31:0] reqData;
	logic [3:0]  reqBe;
	logic        reqReady;
	logic        rspValid;
	logic [31:0] rspData;
	logic        memReqValid;
	logic        memReqWrite;
	logic [31:0] memReqAddr;
	logic [31:0] memReqData;
	logic [3:0]  memReqBe;
	logic        memReqReady;
	logic        memRspValid;
	logic [31:0] memRspData;

	logic [31:0] shadow [logic [29:0]];
	logic        ceShadow = 1'b0;
	logic [31:0] expectData = '0;
	int          expectReads = 0;
	logic [31:0] curAddr = '0;
	logic [31:0] curData = '0;
	logic [3:0]  curBe = '0;
	logic        curWrite = 1'b0;
	logic        curIsMem = 1'b0;
	logic [31:0] lastReadAddr = '0;
	int          memReads = 0;
	int          memWrites = 0;
	int          valueErrors = 0;
	int          otherErrors = 0;

	tbClock clk0 (
		.CLK   (CLK),
		.RST_N (RST_N)
	);

	memModel #(
		.fillKey (fillKey)
	) mem0 (
		.CLK         (CLK),
		.memReqValid (memReqValid),
		.memReqWrite (memReqWrite),
		.memReqAddr  (memReqAddr),
		.memReqData  (memReqData),
		.memReqBe    (memReqBe),
		.memReqReady (memReqReady),
		.memRspValid (memRspValid),
		.memRspData  (memRspData)
	);

	cacheTop #(
		.ccrAddr (ccrAddr)
	) dut0 (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.reqValid    (reqValid),
		.reqWrite    (reqWrite),
		.reqAddr     (reqAddr),
		.reqData     (reqData),
		.reqBe       (reqBe),
		.reqReady    (reqReady),
		.rspValid    (rspValid),
		.rspData     (rspData),
		.memReqValid (memReqValid),
		.memReqWrite (memReqWrite),
		.memReqAddr  (memReqAddr),
		.memReqData  (memReqData),
		.memReqBe    (memReqBe),
		.memReqReady (memReqReady),
		.memRspValid (memRspValid),
		.memRspData  (memRspData)
	);

	// regions 000, 001 and 111 reach memory, except the control register.
	function automatic logic inMemRegion(input logic [31:0] addr);
		return (addr != ccrAddr) && (addr[31:29] == 3'b000 || addr[31:29] == 3'b001 ||
			addr[31:29] == 3'b111);
	endfunction

	function automatic logic [31:0] expectedWord(input logic [31:0] addr);
		if (shadow.exists(addr[31:2])) begin
			return shadow[addr[31:2]];
		end
		return {addr[31:2], 2'b00} ^ fillKey;
	endfunction

	task automatic startRequest(input logic write, input logic [31:0] addr,
		input logic [31:0] data, input logic [3:0] be);
		while (!reqReady) begin
			@(posedge CLK);
			#1;
		end
		reqValid = 1'b1;
		reqWrite = write;
		reqAddr = addr;
		reqData = data;
		reqBe = be;
		@(posedge CLK);
		#1;
		reqValid = 1'b0;
	endtask

	task automatic readAt(input logic [31:0] addr, input int reads);
		expectReads = reads;
		expectData = (addr == ccrAddr) ? {4{7'b0, ceShadow}} : expectedWord(addr);
		startRequest(1'b0, addr, 32'h0, 4'hF);
		while (!rspValid) begin
			@(posedge CLK);
			#1;
		end
		@(posedge CLK);
		#1;
	endtask

	task automatic writeAt(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] be);
		logic [31:0] word;

		if (addr == ccrAddr) begin
			ceShadow = data[0];
		end else if (inMemRegion(addr)) begin
			word = expectedWord(addr);
			for (int b = 0; b < 4; b++) begin
				if (be[b]) begin
					word[8*b +: 8] = data[8*b +: 8];
				end
			end
			shadow[addr[31:2]] = word;
		end
		startRequest(1'b1, addr, data, be);
		while (!reqReady) begin
			@(posedge CLK);
			#1;
		end
	endtask

	// the counters restart with every accepted request.
	always @(posedge CLK) begin
		if (reqValid && reqReady) begin
			curAddr <= reqAddr;
			curData <= reqData;
			curBe <= reqBe;
			curWrite <= reqWrite;
			curIsMem <= inMemRegion(reqAddr);
			memReads <= 0;
			memWrites <= 0;
		end else if (memReqValid && memReqReady) begin
			if (memReqWrite) begin
				memWrites <= memWrites + 1;
			end else begin
				memReads <= memReads + 1;
				lastReadAddr <= memReqAddr;
			end
		end
	end

	rspDataCheck: assert property (@(posedge CLK) disable iff (!RST_N)
		rspValid |-> rspData == expectData)
		else begin
			valueErrors++;
			$display("FAILED %0t rspData got %h expected %h", $time, rspData, expectData);
		end

	readCountCheck: assert property (@(posedge CLK) disable iff (!RST_N)
		rspValid |-> memReads == expectReads)
		else begin
			valueErrors++;
			$display("FAILED %0t memReads got %0d expected %0d", $time, memReads, expectReads);
		end

	// a line fill wraps around, so the requested word is fetched last.
	lastWordCheck: assert property (@(posedge CLK) disable iff (!RST_N)
		rspValid && expectReads == 4 |-> lastReadAddr[31:2] == curAddr[31:2])
		else begin
			valueErrors++;
			$display("FAILED %0t lastReadAddr got %h expected %h", $time,
				{lastReadAddr[31:2], 2'b00}, {curAddr[31:2], 2'b00});
		end

	lineCheck: assert property (@(posedge CLK) disable iff (!RST_N)
		memReqValid && memReqReady && !memReqWrite |-> memReqAddr[31:4] == curAddr[31:4])
		else begin
			otherErrors++;
			$display("at %0t a memory read left the line of the request", $time);
		end

	writeFieldCheck: assert property (@(posedge CLK) disable iff (!RST_N)
		memReqValid && memReqReady && memReqWrite |->
			memReqAddr == curAddr && memReqData == curData && memReqBe == curBe)
		else begin
			valueErrors++;
			$display("FAILED %0t memReqAddr/Data/Be got %h/%h/%h expected %h/%h/%h", $time,
				memReqAddr, memReqData, memReqBe, curAddr, curData, curBe);
		end

	writeCountCheck: assert property (@(posedge CLK) disable iff (!RST_N)
		$rose(reqReady) |-> memWrites == ((curWrite && curIsMem) ? 1 : 0))
		else begin
			valueErrors++;
			$display("FAILED %0t memWrites got %0d expected %0d", $time, memWrites,
				(curWrite && curIsMem) ? 1 : 0);
		end

	writeNoReadCheck: assert property (@(posedge CLK) disable iff (!RST_N)
		$rose(reqReady) && curWrite |-> memReads == 0)
		else begin
			otherErrors++;
			$display("at %0t a CPU write caused a memory read", $time);
		end

	hitLatencyCheck: assert property (@(posedge CLK) disable iff (!RST_N)
		rspValid && expectReads == 0 |-> $past(reqValid && reqReady, 2))
		else begin
			otherErrors++;
			$display("at %0t a hit or register read did not answer in 2 cycles", $time);
		end

	initial begin
		#(watchdogNs);
		$display("timeout after %0d ns, the tests did not finish", watchdogNs);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		reqValid = 1'b0;
		reqWrite = 1'b0;
		reqAddr = '0;
		reqData = '0;
		reqBe = '0;
		@(posedge RST_N);

		// the cache starts disabled, so each cached read goes to memory.
		readAt(lineX + 32'h4, 1);
		readAt(lineX + 32'h4, 1);
		writeAt(ccrAddr, 32'h0000_0001, 4'hF);
		readAt(ccrAddr, 0);
		readAt(lineX + 32'h4, 4);
		for (int w = 0; w < 4; w++) begin
			readAt(lineX + (w << 2), 0);
		end
		writeAt(lineX + 32'h8, 32'hA5A5_1234, 4'b0101);
		readAt(lineX + 32'h8, 0);
		writeAt(missAddr, 32'h0BAD_F00D, 4'hF);
		readAt(missAddr, 4);

		readAt(uncachedAddr, 1);
		readAt(uncachedAddr, 1);
		writeAt(uncachedAddr, 32'hDEAD_BEEF, 4'b1100);
		readAt(uncachedAddr, 1);
		writeAt(ioAddr, 32'h1357_9BDF, 4'hF);
		readAt(ioAddr, 1);

		writeAt(ccrAddr, 32'h0000_0011, 4'hF);
		readAt(ccrAddr, 0);
		readAt(lineX + 32'h4, 4);

		// five tags share one set, so the fifth pushes out the first.
		for (int t = 1; t <= 5; t++) begin
			readAt(lruBase + (t << 10) + 32'h4, 4);
		end
		readAt(lruBase + (1 << 10) + 32'h4, 4);
		readAt(lruBase + (5 << 10) + 32'h4, 0);

		writeAt(ccrAddr, 32'h0000_0000, 4'hF);
		readAt(lineX + 32'h4, 1);
		readAt(lineX + 32'h4, 1);
		writeAt(lineX + 32'h4, 32'h2468_ACE0, 4'b0011);
		writeAt(ccrAddr, 32'h0000_0001, 4'hF);
		readAt(lineX + 32'h4, 0);

		repeat (2) @(posedge CLK);
		$display("errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* verification/memModel.sv */
`timescale 1ns/100ps

module memModel #(
	parameter logic [31:0] fillKey = 32'h0
) (
	input  logic        CLK,
	input  logic        memReqValid,
	input  logic        memReqWrite,
	input  logic [31:0] memReqAddr,
	input  logic [31:0] memReqData,
	input  logic [3:0]  memReqBe,
	output logic        memReqReady,
	output logic        memRspValid,
	output logic [31:0] memRspData
);

	logic [31:0] words [logic [29:0]];
	logic [31:0] lfsr = 32'h8a5e_8cb9;
	logic        taken = 1'b0;
	logic        takenWrite = 1'b0;
	logic [31:0] takenAddr = '0;
	logic [31:0] takenData = '0;
	logic [3:0]  takenBe = '0;

	// fibonacci LFSR with taps 32, 22, 2 and 1. The new bit is the one handed out.
	function automatic logic [31:0] lfsrNext(input logic [31:0] cur);
		return {cur[30:0], cur[31] ^ cur[21] ^ cur[1] ^ cur[0]};
	endfunction

	// words never written read back as their address mixed with the key.
	function automatic logic [31:0] wordAt(input logic [31:0] addr);
		if (words.exists(addr[31:2])) begin
			return words[addr[31:2]];
		end
		return {addr[31:2], 2'b00} ^ fillKey;
	endfunction

	task automatic storeWord(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] be);
		logic [31:0] word;

		word = wordAt(addr);
		for (int b = 0; b < 4; b++) begin
			if (be[b]) begin
				word[8*b +: 8] = data[8*b +: 8];
			end
		end
		words[addr[31:2]] = word;
	endtask

	always @(posedge CLK) begin
		taken <= memReqValid && memReqReady;
		takenWrite <= memReqWrite;
		takenAddr <= memReqAddr;
		takenData <= memReqData;
		takenBe <= memReqBe;
	end

	initial begin
		logic stallBit;

		memReqReady = 1'b0;
		memRspValid = 1'b0;
		memRspData = '0;
		forever begin
			@(posedge CLK);
			#1;
			memRspValid = taken && !takenWrite;
			if (taken && !takenWrite) begin
				memRspData = wordAt(takenAddr);
			end
			if (taken && takenWrite) begin
				storeWord(takenAddr, takenData, takenBe);
			end
			// a stall needs two set bits in a row, so about one cycle in four.
			lfsr = lfsrNext(lfsr);
			stallBit = lfsr[0];
			lfsr = lfsrNext(lfsr);
			memReqReady = !(stallBit && lfsr[0]);
		end
	end

endmodule

/* verification/tbClock.sv */
`timescale 1ns/100ps

module tbClock #(
	parameter int resetCycles = 5
) (
	output logic CLK,
	output logic RST_N
);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// reset is released just after an edge, like the rest of the stimulus.
	initial begin
		RST_N = 1'b0;
		repeat (resetCycles) @(posedge CLK);
		#1;
		RST_N = 1'b1;
	end

endmodule

/* hdl/cacheTop.sv */
`timescale 1ns/100ps

module cacheTop import cachePkg::*; #(
	parameter logic [31:0] ccrAddr = 32'hFFFFFE92
) (
	input  logic        CLK,
	input  logic        RST_N,
	input  logic        reqValid,
	input  logic        reqWrite,
	input  logic [31:0] reqAddr,
	input  logic [31:0] reqData,
	input  logic [3:0]  reqBe,
	output logic        reqReady,
	output logic        rspValid,
	output logic [31:0] rspData,
	output logic        memReqValid,
	output logic        memReqWrite,
	output logic [31:0] memReqAddr,
	output logic [31:0] memReqData,
	output logic [3:0]  memReqBe,
	input  logic        memReqReady,
	input  logic        memRspValid,
	input  logic [31:0] memRspData
);

	cacheAddrT   lookupAddr;
	cacheAddrT   fillAddr;
	wayOneHotT   fillWay;
	logic        fillStrobe;
	wayOneHotT   hitWay;
	wayOneHotT   writeWay;
	logic [3:0]  writeBe;
	logic [31:0] writeData;
	logic [31:0] readData;
	logic        touch;
	wayOneHotT   usedWay;
	wayOneHotT   victimWay;
	logic        purgeAll;

	tagArray tags0 (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.lookupAddr (lookupAddr),
		.fillAddr   (fillAddr),
		.fillWay    (fillWay),
		.fillStrobe (fillStrobe),
		.purgeAll   (purgeAll),
		.hitWay     (hitWay)
	);

	dataArray data0 (
		.CLK        (CLK),
		.lookupAddr (lookupAddr),
		.readWay    (hitWay),
		.writeAddr  (fillAddr),
		.writeWay   (writeWay),
		.writeBe    (writeBe),
		.writeData  (writeData),
		.readData   (readData)
	);

	lruTracker lru0 (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.setIndex  (lookupAddr.f.set),
		.usedWay   (usedWay),
		.touch     (touch),
		.purgeAll  (purgeAll),
		.victimWay (victimWay)
	);

	cacheController #(
		.ccrAddr (ccrAddr)
	) ctrl0 (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.reqValid    (reqValid),
		.reqWrite    (reqWrite),
		.reqAddr     (reqAddr),
		.reqData     (reqData),
		.reqBe       (reqBe),
		.memReqReady (memReqReady),
		.memRspValid (memRspValid),
		.memRspData  (memRspData),
		.hitWay      (hitWay),
		.readData    (readData),
		.victimWay   (victimWay),
		.reqReady    (reqReady),
		.rspValid    (rspValid),
		.rspData     (rspData),
		.memReqValid (memReqValid),
		.memReqWrite (memReqWrite),
		.memReqAddr  (memReqAddr),
		.memReqData  (memReqData),
		.memReqBe    (memReqBe),
		.lookupAddr  (lookupAddr),
		.fillAddr    (fillAddr),
		.fillWay     (fillWay),
		.fillStrobe  (fillStrobe),
		.writeWay    (writeWay),
		.writeBe     (writeBe),
		.writeData   (writeData),
		.touch       (touch),
		.usedWay     (usedWay),
		.purgeAll    (purgeAll)
	);

endmodule

/* hdl/cacheController.sv */
`timescale 1ns/100ps

module cacheController import cachePkg::*; #(
	parameter logic [31:0] ccrAddr = 32'hFFFFFE92
) (
	input  logic        CLK,
	input  logic        RST_N,
	input  logic        reqValid,
	input  logic        reqWrite,
	input  logic [31:0] reqAddr,
	input  logic [31:0] reqData,
	input  logic [3:0]  reqBe,
	input  logic        memReqReady,
	input  logic        memRspValid,
	input  logic [31:0] memRspData,
	input  wayOneHotT   hitWay,
	input  logic [31:0] readData,
	input  wayOneHotT   victimWay,
	output logic        reqReady,
	output logic        rspValid,
	output logic [31:0] rspData,
	output logic        memReqValid,
	output logic        memReqWrite,
	output logic [31:0] memReqAddr,
	output logic [31:0] memReqData,
	output logic [3:0]  memReqBe,
	output cacheAddrT   lookupAddr,
	output cacheAddrT   fillAddr,
	output wayOneHotT   fillWay,
	output logic        fillStrobe,
	output wayOneHotT   writeWay,
	output logic [3:0]  writeBe,
	output logic [31:0] writeData,
	output logic        touch,
	output wayOneHotT   usedWay,
	output logic        purgeAll
);

	localparam logic [2:0] stIdle = 3'd0;
	localparam logic [2:0] stLookup = 3'd1;
	localparam logic [2:0] stFill = 3'd2;
	localparam logic [2:0] stMem = 3'd3;
	localparam logic [2:0] stResp = 3'd4;

	localparam logic [7:0] ccrReadMask = ~(8'h01 << ccrCpBit);

	logic [2:0]  state;
	logic [7:0]  ccr;
	cacheAddrT   reqAddrQ;
	cacheAddrT   memAddrQ;
	logic        reqWriteQ;
	logic [31:0] reqDataQ;
	logic [3:0]  reqBeQ;
	wayOneHotT   wayQ;
	logic        isCcr;
	logic        isCached;
	logic        isMem;
	logic        cacheOn;
	logic        readHit;
	logic        memTaken;
	logic        writeStrobe;

	assign isCcr = reqAddrQ.raw == ccrAddr;
	assign isCached = reqAddrQ.f.region == regionCached;
	assign isMem = isCached || (reqAddrQ.f.region == regionUncached) ||
		((reqAddrQ.f.region == regionIo) && !isCcr);
	assign cacheOn = isCached && ccr[ccrCeBit];
	assign readHit = cacheOn && !reqWriteQ && (|hitWay);
	assign memTaken = memReqValid && memReqReady;

	// write hits patch the line even with the cache off, so it stays coherent with memory.
	assign writeStrobe = (state == stMem) && reqWriteQ && memTaken && (|wayQ);
	assign fillStrobe = (state == stFill) && memRspValid;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= stIdle;
			memReqValid <= 1'b0;
			reqAddrQ <= '0;
		end else begin
			case (state)
				stIdle: begin
					if (reqValid) begin
						reqAddrQ <= reqAddr;
						state <= stLookup;
					end
				end
				stLookup: begin
					if (isCcr || !isMem) begin
						state <= reqWriteQ ? stIdle : stResp;
					end else if (readHit) begin
						state <= stResp;
					end else begin
						state <= (cacheOn && !reqWriteQ) ? stFill : stMem;
						memReqValid <= 1'b1;
					end
				end
				stFill: begin
					if (memTaken) begin
						memReqValid <= 1'b0;
					end
					if (memRspValid) begin
						if (memAddrQ.f.word == reqAddrQ.f.word) begin
							state <= stResp;
						end else begin
							memReqValid <= 1'b1;
						end
					end
				end
				stMem: begin
					if (memTaken) begin
						memReqValid <= 1'b0;
						if (reqWriteQ) begin
							state <= stIdle;
						end
					end
					if (memRspValid) begin
						state <= stResp;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	// the fill starts one word past the requested one, so that word comes back last.
	always_ff @(posedge CLK) begin
		if (reqValid && reqReady) begin
			reqWriteQ <= reqWrite;
			reqDataQ <= reqData;
			reqBeQ <= reqBe;
		end
		if (state == stLookup) begin
			if (cacheOn && !reqWriteQ) begin
				memAddrQ.raw <= {reqAddrQ.raw[31:4], reqAddrQ.f.word + 2'd1, 2'b00};
				wayQ <= victimWay;
			end else begin
				memAddrQ <= reqAddrQ;
				wayQ <= isCached ? hitWay : '0;
			end
			rspData <= isCcr ? {4{ccr & ccrReadMask}} : (readHit ? readData : '0);
		end else if (memRspValid && (state == stFill || state == stMem)) begin
			memAddrQ.f.word <= memAddrQ.f.word + 2'd1;
			rspData <= memRspData;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ccr <= '0;
		end else if (state == stLookup && isCcr && reqWriteQ) begin
			ccr <= reqDataQ[7:0] & ccrWriteMask;
		end else if (ccr[ccrCpBit]) begin
			ccr[ccrCpBit] <= 1'b0;
		end
	end

	assign reqReady = state == stIdle;
	assign rspValid = state == stResp;
	assign memReqWrite = reqWriteQ;
	assign memReqAddr = memAddrQ.raw;
	assign memReqData = reqDataQ;
	assign memReqBe = (state == stFill) ? 4'b1111 : reqBeQ;

	assign lookupAddr = reqAddrQ;
	assign fillAddr = memAddrQ;
	assign fillWay = wayQ;
	assign writeWay = (fillStrobe || writeStrobe) ? wayQ : '0;
	assign writeBe = fillStrobe ? 4'b1111 : reqBeQ;
	assign writeData = fillStrobe ? memRspData : reqDataQ;
	assign touch = ((state == stLookup) && readHit) || fillStrobe || writeStrobe;
	assign usedWay = (state == stLookup) ? hitWay : wayQ;
	assign purgeAll = ccr[ccrCpBit];

	memHold: assert property (@(posedge CLK) disable iff (!RST_N)
		memReqValid && !memReqReady |=> memReqValid && $stable(memReqAddr));

endmodule

/* hdl/lruTracker.sv */
`timescale 1ns/100ps

module lruTracker import cachePkg::*; (
	input  logic               CLK,
	input  logic               RST_N,
	input  logic [setBits-1:0] setIndex,
	input  wayOneHotT          usedWay,
	input  logic               touch,
	input  logic               purgeAll,
	output wayOneHotT          victimWay
);

	lruT lruState [2**setBits];

	// a pair bit is set when the higher way of the pair was used last.
	function automatic lruT lruUpdate(input wayOneHotT way, input lruT cur);
		lruT next;

		next = cur;
		case (1'b1)
			way[3]: begin
				next[3] = 1'b1;
				next[1] = 1'b1;
				next[0] = 1'b1;
			end
			way[2]: begin
				next[4] = 1'b1;
				next[2] = 1'b1;
				next[0] = 1'b0;
			end
			way[1]: begin
				next[5] = 1'b1;
				next[2] = 1'b0;
				next[1] = 1'b0;
			end
			way[0]: begin
				next[5] = 1'b0;
				next[4] = 1'b0;
				next[3] = 1'b0;
			end
			default: next = cur;
		endcase
		return next;
	endfunction

	function automatic wayOneHotT lruVictim(input lruT cur);
		wayOneHotT way;

		casez (cur)
			6'b111???: way = 4'b0001;
			6'b0??11?: way = 4'b0010;
			6'b?0?0?1: way = 4'b0100;
			6'b??0?00: way = 4'b1000;
			default:   way = 4'b0001;
		endcase
		return way;
	endfunction

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			lruState <= '{default: '0};
		end else if (purgeAll) begin
			lruState <= '{default: '0};
		end else if (touch) begin
			lruState[setIndex] <= lruUpdate(usedWay, lruState[setIndex]);
		end
	end

	assign victimWay = lruVictim(lruState[setIndex]);

endmodule

/* hdl/dataArray.sv */
`timescale 1ns/100ps

module dataArray import cachePkg::*; (
	input  logic        CLK,
	input  cacheAddrT   lookupAddr,
	input  wayOneHotT   readWay,
	input  cacheAddrT   writeAddr,
	input  wayOneHotT   writeWay,
	input  logic [3:0]  writeBe,
	input  logic [31:0] writeData,
	output logic [31:0] readData
);

	logic [31:0] words [wayCount][2**(setBits+2)];

	always_ff @(posedge CLK) begin
		for (int w = 0; w < wayCount; w++) begin
			for (int b = 0; b < 4; b++) begin
				if (writeWay[w] && writeBe[b]) begin
					words[w][{writeAddr.f.set, writeAddr.f.word}][8*b +: 8] <= writeData[8*b +: 8];
				end
			end
		end
	end

	// readWay is the one-hot hit vector, so an OR of the selected words is enough.
	always_comb begin
		readData = '0;
		for (int w = 0; w < wayCount; w++) begin
			if (readWay[w]) begin
				readData = readData | words[w][{lookupAddr.f.set, lookupAddr.f.word}];
			end
		end
	end

	writeOneWay: assert property (@(posedge CLK) $onehot0(writeWay));

endmodule

/* hdl/tagArray.sv */
`timescale 1ns/100ps

module tagArray import cachePkg::*; (
	input  logic      CLK,
	input  logic      RST_N,
	input  cacheAddrT lookupAddr,
	input  cacheAddrT fillAddr,
	input  wayOneHotT fillWay,
	input  logic      fillStrobe,
	input  logic      purgeAll,
	output wayOneHotT hitWay
);

	logic [tagBits-1:0] tags [wayCount][2**setBits];
	logic [wayCount-1:0][2**setBits-1:0] valid;

	always_ff @(posedge CLK) begin
		for (int w = 0; w < wayCount; w++) begin
			if (fillStrobe && fillWay[w]) begin
				tags[w][fillAddr.f.set] <= fillAddr.f.tag;
			end
		end
	end

	// a purge drops every line at once, the tags themselves are left as they are.
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			valid <= '0;
		end else if (purgeAll) begin
			valid <= '0;
		end else if (fillStrobe) begin
			for (int w = 0; w < wayCount; w++) begin
				if (fillWay[w]) begin
					valid[w][fillAddr.f.set] <= 1'b1;
				end
			end
		end
	end

	always_comb begin
		for (int w = 0; w < wayCount; w++) begin
			hitWay[w] = valid[w][lookupAddr.f.set] &&
				(tags[w][lookupAddr.f.set] == lookupAddr.f.tag);
		end
	end

	// fills always go to one victim way, so a tag never sits twice in a set.
	hitOneHot: assert property (@(posedge CLK) disable iff (!RST_N) $onehot0(hitWay));

endmodule

/* hdl/cachePkg.sv */
package cachePkg;

	localparam int wayCount = 4;
	localparam int setBits = 6;
	localparam int tagBits = 19;

	typedef logic [wayCount-1:0] wayOneHotT;

	// one bit per pair of ways, (0,1) (0,2) (0,3) (1,2) (1,3) (2,3) from bit 5 down.
	typedef logic [5:0] lruT;

	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [2:0]         region;
			logic [tagBits-1:0] tag;
			logic [setBits-1:0] set;
			logic [1:0]         word;
			logic [1:0]         byteSel;
		} f;
	} cacheAddrT;

	localparam logic [2:0] regionCached = 3'b000;
	localparam logic [2:0] regionUncached = 3'b001;
	localparam logic [2:0] regionIo = 3'b111;

	localparam int ccrCeBit = 0;
	localparam int ccrCpBit = 4;
	localparam logic [7:0] ccrWriteMask = 8'h11;

endpackage
